//--- filelist.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/alu_unit.sv
verilog/mem_unit.sv
verilog/reorder_buffer.sv
verilog/exec_core.sv
sim/exec_core_props.sv
sim/exec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module exec_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vexec_core_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

//--- sim/exec_core_props.sv
`timescale 1ns/1ns

module exec_core_props (
    input logic                clk,
    input logic                rst,
    input logic                issue_valid,
    input logic                rob_full,
    input logic                flush,
    input core_pkg::commit_t   commit,
    input core_pkg::exec_req_t alu_req,
    input core_pkg::exec_req_t mem_req
);

    // Covers every reset edge and the first edge after release
    quiet_in_reset: assert property (@(posedge clk)
        $past(rst) |-> !commit.valid && !flush && !rob_full)
        else $error("commit, flush or rob_full active during or just after reset");

    flush_with_commit: assert property (@(posedge clk) disable iff (rst)
        flush |-> commit.valid)
        else $error("flush pulsed without a commit");

    // A refused issue must not reach either unit
    full_blocks_issue: assert property (@(posedge clk) disable iff (rst)
        issue_valid && rob_full |=> !alu_req.valid && !mem_req.valid)
        else $error("request sent for an issue offered while the buffer was full");

endmodule

bind reorder_buffer exec_core_props props_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .rob_full    (rob_full),
    .flush       (flush),
    .commit      (commit),
    .alu_req     (alu_req),
    .mem_req     (mem_req)
);

//--- sim/exec_core_tb.sv
`timescale 1ns/1ns

module exec_core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    // One expected event from the trace
    typedef struct packed {
        logic [7:0]  kind;
        commit_t     cmt;
        logic [31:0] epc;
        logic [31:0] n_commit;
        logic [31:0] n_branch;
        logic [31:0] n_miss;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        issue_valid;
    issue_t      issue;
    logic        rob_full;
    commit_t     commit;
    logic        flush;
    logic [31:0] exc_epc;
    exc_cause_e  exc_cause;
    logic [31:0] commit_count;
    logic [31:0] branch_count;
    logic [31:0] miss_count;

    issue_t  issues [$];
    int      issue_gate [$];
    expect_t expects [$];
    int      consumed = 0;
    int      cycles = 0;
    int      cycle_limit = 0;
    int      commit_errors = 0;
    int      exc_errors = 0;
    int      count_errors = 0;
    int      other_errors = 0;

    exec_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .rob_full     (rob_full),
        .commit       (commit),
        .flush        (flush),
        .exc_epc      (exc_epc),
        .exc_cause    (exc_cause),
        .commit_count (commit_count),
        .branch_count (branch_count),
        .miss_count   (miss_count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic read_trace();
        int          fd;
        string       line;
        logic [31:0] f [5];
        issue_t      iss;
        expect_t     e;
        bit          pending_branch [$];
        fd = $fopen("sim/exec_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file sim/exec_trace.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            f = '{default: '0};
            iss = '0;
            e = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4]));
            case (line[0])
                "I": begin
                    iss.instr = f[0];
                    iss.op_a = f[1];
                    iss.op_b = f[2];
                    iss.pc = f[3];
                    iss.predicted_taken = f[4][0];
                    issues.push_back(iss);
                    pending_branch.push_back(iss.instr.i.opcode == op_beq ||
                                             iss.instr.i.opcode == op_bne);
                    // Issue waits for every expected record listed before it
                    issue_gate.push_back(expects.size());
                end
                "C": begin
                    e.kind = "C";
                    e.cmt.valid = 1'b1;
                    e.cmt.rd = f[0][4:0];
                    e.cmt.data = f[1];
                    e.cmt.wen = f[2][0];
                    e.cmt.mispredict = f[3][0];
                    e.cmt.redirect_pc = f[4];
                    if (pending_branch.size() > 0) begin
                        e.cmt.is_branch = pending_branch.pop_front();
                    end
                    // Younger issues are discarded by a mispredict
                    if (e.cmt.mispredict) begin
                        pending_branch.delete();
                    end
                    expects.push_back(e);
                end
                "X": begin
                    e.kind = "X";
                    e.epc = f[0];
                    expects.push_back(e);
                    pending_branch.delete();
                end
                "N": begin
                    e.kind = "N";
                    e.n_commit = f[0];
                    e.n_branch = f[1];
                    e.n_miss = f[2];
                    expects.push_back(e);
                end
                default: begin
                    $display("Unknown record in trace file: %s", line);
                    other_errors++;
                end
            endcase
        end
        $fclose(fd);
    endtask

    function automatic bit word_ok(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_commit(input commit_t exp, input commit_t act);
        bit ok;
        ok = word_ok("commit.rd", 32'(exp.rd), 32'(act.rd));
        ok &= word_ok("commit.data", exp.data, act.data);
        ok &= word_ok("commit.wen", 32'(exp.wen), 32'(act.wen));
        ok &= word_ok("commit.is_branch", 32'(exp.is_branch), 32'(act.is_branch));
        ok &= word_ok("commit.mispredict", 32'(exp.mispredict), 32'(act.mispredict));
        ok &= word_ok("commit.redirect_pc", exp.redirect_pc, act.redirect_pc);
        if (!ok) begin
            commit_errors++;
        end
    endtask

    task automatic check_exception(input logic [31:0] exp_epc, input exc_cause_e exp_cause);
        bit ok;
        ok = word_ok("exc_epc", exp_epc, exc_epc);
        ok &= word_ok("exc_cause", 32'(exp_cause), 32'(exc_cause));
        if (!ok) begin
            exc_errors++;
        end
    endtask

    task automatic check_counters(input logic [31:0] exp_commits,
                                  input logic [31:0] exp_branches,
                                  input logic [31:0] exp_misses);
        bit ok;
        ok = word_ok("commit_count", exp_commits, commit_count);
        ok &= word_ok("branch_count", exp_branches, branch_count);
        ok &= word_ok("miss_count", exp_misses, miss_count);
        if (!ok) begin
            count_errors++;
        end
    endtask

    task automatic take_commit();
        bit exp_flush;
        if (consumed >= expects.size() || expects[consumed].kind != "C") begin
            $display("Unexpected commit of rd %0d at %0t ns", commit.rd, $time);
            other_errors++;
            return;
        end
        exp_flush = expects[consumed].cmt.mispredict;
        check_commit(expects[consumed].cmt, commit);
        consumed++;
        // A faulting access flushes and leaves its exception state
        if (consumed < expects.size() && expects[consumed].kind == "X") begin
            exp_flush = 1'b1;
            check_exception(expects[consumed].epc, exc_invalid_dm_addr);
            consumed++;
        end
        if (!word_ok("flush", 32'(exp_flush), 32'(flush))) begin
            commit_errors++;
        end
    endtask

    task automatic finish_run();
        int total;
        total = commit_errors + exc_errors + count_errors + other_errors;
        $display("Errors: commit %0d, exception %0d, counters %0d, other %0d",
                 commit_errors, exc_errors, count_errors, other_errors);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst && commit.valid) begin
            take_commit();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d expected records seen",
                     cycles, consumed, expects.size());
            other_errors++;
            finish_run();
        end
    end

    initial begin
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        read_trace();
        cycle_limit = 40 * issues.size() + 100;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int n = 0; n < issues.size(); n++) begin
            while (consumed < issue_gate[n]) begin
                issue_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            issue_valid = 1'b1;
            issue = issues[n];
            // Held while the buffer is full
            while (rob_full) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2;
        end
        issue_valid = 1'b0;
        while (consumed < expects.size() && expects[consumed].kind != "N") begin
            @(posedge clk);
        end
        // Room for a stray wrong-path commit to show up
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (consumed < expects.size()) begin
            check_counters(expects[consumed].n_commit, expects[consumed].n_branch,
                           expects[consumed].n_miss);
            consumed++;
        end
        if (consumed != expects.size()) begin
            $display("Trace records left unchecked: %0d", expects.size() - consumed);
            other_errors++;
        end
        finish_run();
    end

endmodule

//--- sim/exec_trace.txt
# I instr op_a op_b pc predicted_taken | C rd data wen mispredict redirect_pc
# X epc | N commits branches misses | all fields hex
I ac220004 00000020 cafe0001 00000010 0
I 8c230004 00000020 00000000 00000011 0
I 00222020 00000005 00000007 00000012 0
I 00222820 7fffffff 00000001 00000013 0
I 00223022 00000003 00000005 00000014 0
I 00223824 f0f0f0f0 0ff00ff0 00000015 0
I 00224025 f0f0f0f0 0ff00ff0 00000016 0
I 00224826 f0f0f0f0 0ff00ff0 00000017 0
I 0022502a ffffffff 00000001 00000018 0
I 0022582a 00000001 ffffffff 00000019 0
I 00226100 00000000 0000abcd 0000001a 0
I 00226a02 00000000 80001234 0000001b 0
I 202effff 00000010 00000000 0000001c 0
I 202f0100 00000023 00000000 0000001d 0
I 3030f00f ffffffff 00000000 0000001e 0
I 34318001 12340000 00000000 0000001f 0
I 3832ffff 0000ff00 00000000 00000020 0
I 2833fffe fffffffd 00000000 00000021 0
I 0022a020 00000100 00000200 00000022 0
I 0022a822 00001000 00000001 00000023 0
I 0022b025 00000000 00000055 00000024 0
I 0022b826 12345678 12345678 00000025 0
C 02 00000000 0 0 00000011
C 03 cafe0001 1 0 00000012
C 04 0000000c 1 0 00000013
C 05 80000000 1 0 00000014
C 06 fffffffe 1 0 00000015
C 07 00f000f0 1 0 00000016
C 08 fff0fff0 1 0 00000017
C 09 ff00ff00 1 0 00000018
C 0a 00000001 1 0 00000019
C 0b 00000000 1 0 0000001a
C 0c 000abcd0 1 0 0000001b
C 0d 00800012 1 0 0000001c
C 0e 0000000f 1 0 0000001d
C 0f 00000123 1 0 0000001e
C 10 0000f00f 1 0 0000001f
C 11 12348001 1 0 00000020
C 12 000000ff 1 0 00000021
C 13 00000001 1 0 00000022
C 14 00000300 1 0 00000023
C 15 00000fff 1 0 00000024
C 16 00000055 1 0 00000025
C 17 00000000 1 0 00000026
I 10220005 00000007 00000007 00000026 1
I 1422fff0 00000001 00000002 0000002c 0
I 00222020 00000001 00000001 0000002d 0
I 00222820 00000001 00000001 0000002e 0
C 02 00000000 0 0 0000002c
C 02 00000000 0 1 0000001d
I 8c230000 00000100 00000000 0000001d 0
I 00222020 00000002 00000002 0000001e 0
C 03 00000000 0 0 0000001e
X 0000001d
N 00000019 00000002 00000001

//--- verilog/alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::exec_req_t req,
    output core_pkg::exec_res_t res
);
    import isa_pkg::*;
    import core_pkg::*;

    instr_u      w;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] seq_pc;
    logic [31:0] result;
    logic        taken;

    assign w        = req.instr;
    assign imm_sext = {{16{w.i.imm[15]}}, w.i.imm};
    assign imm_zext = {16'd0, w.i.imm};
    assign seq_pc   = req.pc + 32'd1;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (w.i.opcode)
            op_rtype: begin
                // Shifts act on rt by shamt
                case (w.r.funct)
                    fn_add: result = req.op_a + req.op_b;
                    fn_sub: result = req.op_a - req.op_b;
                    fn_and: result = req.op_a & req.op_b;
                    fn_or:  result = req.op_a | req.op_b;
                    fn_xor: result = req.op_a ^ req.op_b;
                    fn_slt: result = {31'd0, $signed(req.op_a) < $signed(req.op_b)};
                    fn_sll: result = req.op_b << w.r.shamt;
                    fn_srl: result = req.op_b >> w.r.shamt;
                    default: result = '0;
                endcase
            end
            op_addi: result = req.op_a + imm_sext;
            op_slti: result = {31'd0, $signed(req.op_a) < $signed(imm_sext)};
            // Logical immediates are zero extended
            op_andi: result = req.op_a & imm_zext;
            op_ori:  result = req.op_a | imm_zext;
            op_xori: result = req.op_a ^ imm_zext;
            op_beq:  taken = req.op_a == req.op_b;
            op_bne:  taken = req.op_a != req.op_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res <= '0;
        end else begin
            res.valid  <= req.valid;
            res.tag    <= req.tag;
            res.data   <= result;
            res.taken  <= taken;
            res.target <= taken ? seq_pc + imm_sext : seq_pc;
            res.fault  <= 1'b0;
        end
    end

endmodule

//--- verilog/core_pkg.sv
`include "ooo_settings.svh"

package core_pkg;

    typedef logic [`OOO_TAG_BITS-1:0] rob_tag_t;

    // From the dispatcher, operands already resolved
    typedef struct packed {
        isa_pkg::instr_u instr;
        logic [31:0]     op_a;
        logic [31:0]     op_b;
        logic [31:0]     pc;
        logic            predicted_taken;
    } issue_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        isa_pkg::instr_u instr;
        logic [31:0]     op_a;
        logic [31:0]     op_b;
        logic [31:0]     pc;
    } exec_req_t;

    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
        logic        fault;
    } exec_res_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        wen;
        logic        is_branch;
        logic        mispredict;
        logic [31:0] redirect_pc;
    } commit_t;

    typedef enum logic [1:0] {
        exc_none            = 2'd0,
        exc_invalid_dm_addr = 2'd2
    } exc_cause_e;

endpackage

//--- verilog/exec_core.sv
`timescale 1ns/1ns

module exec_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  core_pkg::issue_t     issue,
    output logic                 rob_full,
    output core_pkg::commit_t    commit,
    output logic                 flush,
    output logic [31:0]          exc_epc,
    output core_pkg::exc_cause_e exc_cause,
    output logic [31:0]          commit_count,
    output logic [31:0]          branch_count,
    output logic [31:0]          miss_count
);
    import core_pkg::*;

    exec_req_t alu_req;
    exec_req_t mem_req;
    exec_res_t alu_res;
    exec_res_t mem_res;

    reorder_buffer rob_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .rob_full     (rob_full),
        .alu_req      (alu_req),
        .mem_req      (mem_req),
        .alu_res      (alu_res),
        .mem_res      (mem_res),
        .commit       (commit),
        .flush        (flush),
        .exc_epc      (exc_epc),
        .exc_cause    (exc_cause),
        .commit_count (commit_count),
        .branch_count (branch_count),
        .miss_count   (miss_count)
    );

    // Both units report straight back to the reorder buffer
    alu_unit alu_i (
        .clk (clk),
        .rst (rst),
        .req (alu_req),
        .res (alu_res)
    );

    mem_unit mem_i (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .res (mem_res)
    );

endmodule

//--- verilog/isa_pkg.sv
package isa_pkg;

    // Primary opcodes
    typedef enum logic [5:0] {
        op_rtype = 6'd0,
        op_beq   = 6'd4,
        op_bne   = 6'd5,
        op_addi  = 6'd8,
        op_slti  = 6'd10,
        op_andi  = 6'd12,
        op_ori   = 6'd13,
        op_xori  = 6'd14,
        op_lw    = 6'd35,
        op_sw    = 6'd43
    } opcode_e;

    // R-type function codes
    typedef enum logic [5:0] {
        fn_sll = 6'd0,
        fn_srl = 6'd2,
        fn_add = 6'd32,
        fn_sub = 6'd34,
        fn_and = 6'd36,
        fn_or  = 6'd37,
        fn_xor = 6'd38,
        fn_slt = 6'd42
    } funct_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funct_e      funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same 32-bit word, two decodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

//--- verilog/mem_unit.sv
`timescale 1ns/1ns
`include "ooo_settings.svh"

module mem_unit (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::exec_req_t req,
    output core_pkg::exec_res_t res
);
    import isa_pkg::*;
    import core_pkg::*;

    instr_u                       w;
    logic [31:0]                  ea;
    logic                         in_range;
    logic                         is_store;
    logic [31:0]                  dm [`OOO_DM_DEPTH];
    logic                         s1_valid;
    rob_tag_t                     s1_tag;
    logic                         s1_store;
    logic                         s1_fault;
    logic [`OOO_DM_ADDR_BITS-1:0] s1_index;
    logic [31:0]                  s1_next_pc;

    assign w        = req.instr;
    assign ea       = req.op_a + {{16{w.i.imm[15]}}, w.i.imm};
    assign in_range = ea < 32'(`OOO_DM_DEPTH);
    assign is_store = w.i.opcode == op_sw;

    initial begin
        for (int k = 0; k < `OOO_DM_DEPTH; k++) begin
            dm[k] = '0;
        end
    end

    // Store lands in stage one, never for a bad address
    always @(posedge clk) begin
        if (req.valid && is_store && in_range) begin
            dm[ea[`OOO_DM_ADDR_BITS-1:0]] <= req.op_b;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag     <= req.tag;
        s1_store   <= is_store;
        s1_fault   <= !in_range;
        s1_index   <= ea[`OOO_DM_ADDR_BITS-1:0];
        s1_next_pc <= req.pc + 32'd1;
    end

    // Stage two returns load data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res <= '0;
        end else begin
            res.valid  <= s1_valid;
            res.tag    <= s1_tag;
            res.data   <= (s1_store || s1_fault) ? 32'd0 : dm[s1_index];
            res.taken  <= 1'b0;
            res.target <= s1_next_pc;
            res.fault  <= s1_fault;
        end
    end

endmodule

//--- verilog/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Reorder buffer sizing
`define OOO_TAG_BITS 4
`define OOO_ROB_DEPTH 16

// Data memory, word addressed
`define OOO_DM_DEPTH 256
`define OOO_DM_ADDR_BITS 8

`endif

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ns
`include "ooo_settings.svh"

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  core_pkg::issue_t     issue,
    output logic                 rob_full,
    output core_pkg::exec_req_t  alu_req,
    output core_pkg::exec_req_t  mem_req,
    input  core_pkg::exec_res_t  alu_res,
    input  core_pkg::exec_res_t  mem_res,
    output core_pkg::commit_t    commit,
    output logic                 flush,
    output logic [31:0]          exc_epc,
    output core_pkg::exc_cause_e exc_cause,
    output logic [31:0]          commit_count,
    output logic [31:0]          branch_count,
    output logic [31:0]          miss_count
);
    import isa_pkg::*;
    import core_pkg::*;

    // Entry storage
    logic [`OOO_ROB_DEPTH-1:0] e_alloc;
    logic                      e_done   [`OOO_ROB_DEPTH];
    logic [31:0]               e_data   [`OOO_ROB_DEPTH];
    logic                      e_fault  [`OOO_ROB_DEPTH];
    logic                      e_taken  [`OOO_ROB_DEPTH];
    logic [31:0]               e_target [`OOO_ROB_DEPTH];
    logic                      e_pred   [`OOO_ROB_DEPTH];
    logic [4:0]                e_dest   [`OOO_ROB_DEPTH];
    logic                      e_wen    [`OOO_ROB_DEPTH];
    logic [31:0]               e_pc     [`OOO_ROB_DEPTH];
    logic                      e_branch [`OOO_ROB_DEPTH];

    rob_tag_t                  head;
    rob_tag_t                  tail;
    logic [`OOO_TAG_BITS:0]    count;
    logic [`OOO_TAG_BITS:0]    count_next;

    opcode_e                   issue_op;
    logic                      is_mem;
    logic                      is_store;
    logic                      is_branch_op;
    logic                      accept;
    logic                      do_alloc;
    logic                      retire;
    logic                      head_miss;
    logic                      do_flush;
    exec_req_t                 new_req;
    exec_res_t                 ports [2];

    assign issue_op     = issue.instr.i.opcode;
    assign is_store     = issue_op == op_sw;
    assign is_mem       = is_store || issue_op == op_lw;
    assign is_branch_op = issue_op == op_beq || issue_op == op_bne;

    assign rob_full   = count == (`OOO_TAG_BITS+1)'(`OOO_ROB_DEPTH);
    assign accept     = issue_valid && !rob_full && !flush;
    assign retire     = count != '0 && e_done[head];
    assign head_miss  = e_branch[head] && (e_taken[head] != e_pred[head]);
    assign do_flush   = retire && (head_miss || e_fault[head]);
    assign do_alloc   = accept && !do_flush;
    assign count_next = count + (`OOO_TAG_BITS+1)'(do_alloc) - (`OOO_TAG_BITS+1)'(retire);

    assign ports[0] = alu_res;
    assign ports[1] = mem_res;

    always_comb begin
        new_req.valid = 1'b0;
        new_req.tag   = tail;
        new_req.instr = issue.instr;
        new_req.op_a  = issue.op_a;
        new_req.op_b  = issue.op_b;
        new_req.pc    = issue.pc;
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            e_done[tail]   <= 1'b0;
            e_pred[tail]   <= issue.predicted_taken;
            e_dest[tail]   <= (issue_op == op_rtype) ? issue.instr.r.rd : issue.instr.i.rt;
            e_wen[tail]    <= !(is_store || is_branch_op);
            e_pc[tail]     <= issue.pc;
            e_branch[tail] <= is_branch_op;
        end
        // Stale tags from a flushed path are no longer allocated
        for (int p = 0; p < 2; p++) begin
            if (ports[p].valid && e_alloc[ports[p].tag]) begin
                e_done[ports[p].tag]   <= 1'b1;
                e_data[ports[p].tag]   <= ports[p].data;
                e_fault[ports[p].tag]  <= ports[p].fault;
                e_taken[ports[p].tag]  <= ports[p].taken;
                e_target[ports[p].tag] <= ports[p].target;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            e_alloc      <= '0;
            alu_req      <= '0;
            mem_req      <= '0;
            commit       <= '0;
            flush        <= 1'b0;
            exc_epc      <= '0;
            exc_cause    <= exc_none;
            commit_count <= '0;
            branch_count <= '0;
            miss_count   <= '0;
        end else begin
            alu_req       <= new_req;
            alu_req.valid <= do_alloc && !is_mem;
            mem_req       <= new_req;
            mem_req.valid <= do_alloc && is_mem;

            if (do_flush) begin
                // New tags continue past the discarded ones
                head    <= tail;
                count   <= '0;
                e_alloc <= '0;
            end else begin
                if (retire) begin
                    head          <= head + 1'b1;
                    e_alloc[head] <= 1'b0;
                end
                if (do_alloc) begin
                    tail          <= tail + 1'b1;
                    e_alloc[tail] <= 1'b1;
                end
                count <= count_next;
            end

            flush              <= do_flush;
            commit.valid       <= retire;
            commit.rd          <= e_dest[head];
            commit.data        <= e_data[head];
            commit.wen         <= e_wen[head] && !e_fault[head];
            commit.is_branch   <= e_branch[head];
            commit.mispredict  <= head_miss;
            commit.redirect_pc <= e_target[head];

            if (retire && e_fault[head]) begin
                exc_epc   <= e_pc[head];
                exc_cause <= exc_invalid_dm_addr;
            end

            commit_count <= commit_count + 32'(retire);
            branch_count <= branch_count + 32'(retire && e_branch[head]);
            miss_count   <= miss_count + 32'(retire && head_miss);
        end
    end

endmodule
